//--- uart_core.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_ctrl_if.sv
hw/uart_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_core.sv
verification/uart_core_sva.sv
verification/uart_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --timescale 1ns/1ps \
   --top-module uart_core_tb \
   -f uart_core.f \
   -o uart_core_sim

./obj_dir/uart_core_sim

//--- verification/uart_core_tb.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_core_tb;

   localparam int TX_FRAMES = 4;
   localparam int RX_FRAMES = 3;
   localparam int MAX_DIV   = 16;
   // 41 fixed accesses plus a few extra receive valid polls
   localparam int ACCESSES  = 48;
   // all frames at the slowest divider plus bus traffic, doubled
   localparam int LIMIT = ((TX_FRAMES + RX_FRAMES + 1) * 10 * MAX_DIV + 100 * ACCESSES) * 2;

   logic        clk;
   logic        rst_int;
   logic        valid;
   logic        write;
   logic        ready;
   logic        txd;
   logic        rts;
   logic        rxd;
   logic        cts;
   logic [2:0]  address;
   logic [31:0] wdata;
   logic [31:0] rdata;
   logic [9:0]  exp_q[$];
   logic [9:0]  act_q[$];
   int          cycles = 0;
   int          frames_checked = 0;

   uart_core i_uart_core (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("run stopped, no progress after %0d cycles", cycles);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [`UART_DATA_W+1:0] expected_frame(input uart_pkg::uart_byte_t b);
      logic [`UART_DATA_W+1:0] frm;
      // start bit low, data LSB first, stop bit high
      frm[0] = 1'b0;
      for (int i = 0; i < `UART_DATA_W; i++) begin
         frm[i + 1] = b[i];
      end
      frm[`UART_DATA_W+1] = 1'b1;
      return frm;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         $display("Something failed");
         $fatal(1, "check mismatch");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // bus and serial tasks
   //////////////////////////////////////////////////////////////////////

   task automatic bus_access(input logic wr, input logic [2:0] addr, input logic [31:0] data,
                             output logic [31:0] rd);
      @(negedge clk);
      valid   = 1'b1;
      write   = wr;
      address = addr;
      wdata   = data;
      do @(negedge clk); while (ready !== 1'b1);
      rd    = rdata;
      valid = 1'b0;
   endtask

   task automatic bus_write(input logic [2:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(1'b1, addr, data, unused);
   endtask

   task automatic bus_read(input logic [2:0] addr, output logic [31:0] rd);
      bus_access(1'b0, addr, 32'd0, rd);
   endtask

   task automatic send_frame(input uart_pkg::uart_byte_t b, input int div_v);
      logic [9:0] frm;
      frm = expected_frame(b);
      for (int i = 0; i < 10; i++) begin
         rxd = frm[i];
         repeat (div_v) @(negedge clk);
      end
   endtask

   // samples at bit centres, starting half a bit after the start edge
   task automatic monitor_frame(input int div_v, output logic [9:0] frm);
      @(negedge clk);
      while (txd !== 1'b0) @(negedge clk);
      repeat (div_v / 2) @(negedge clk);
      for (int i = 0; i < 10; i++) begin
         frm[i] = txd;
         if (i < 9) repeat (div_v) @(negedge clk);
      end
   endtask

   // frame comparison
   initial begin
      logic [9:0] e;
      logic [9:0] a;
      forever begin
         @(posedge clk);
         if (act_q.size() != 0) begin
            a = act_q.pop_front();
            e = exp_q.pop_front();
            check("tx frame", 32'(e), 32'(a));
            frames_checked++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   initial begin
      int                   div_v;
      uart_pkg::uart_byte_t b;
      logic [9:0]           frm;
      logic [31:0]          rd;
      rst_int = 1'b1;
      valid   = 1'b0;
      write   = 1'b0;
      address = 3'd0;
      wdata   = 32'd0;
      rxd     = 1'b1;
      cts     = 1'b1;
      void'($urandom(32'hebabaa81));
      repeat (8) @(negedge clk);
      rst_int = 1'b0;

      // reset state
      bus_read(uart_pkg::UART_DIV, rd);
      check("reset divider", 32'(`UART_DIV_RESET), rd);
      bus_read(uart_pkg::UART_RX_VALID, rd);
      check("reset rx valid", 32'd0, rd);
      bus_read(uart_pkg::UART_TX_WAIT, rd);
      check("reset tx wait", 32'd0, rd);
      check("reset txd", 32'd1, 32'(txd));
      check("reset rts", 32'd0, 32'(rts));
      bus_read(3'd6, rd);
      check("unmapped read", 32'hffff_ffff, rd);

      // transmit
      for (int t = 0; t < TX_FRAMES; t++) begin
         div_v = 4 + int'($urandom % 13);
         b     = 8'($urandom);
         bus_write(uart_pkg::UART_DIV, 32'(div_v));
         exp_q.push_back(expected_frame(b));
         fork
            begin
               bus_write(uart_pkg::UART_DATA, 32'(b));
               bus_read(uart_pkg::UART_TX_WAIT, rd);
               check("tx wait busy", 32'd1, rd);
            end
            begin
               monitor_frame(div_v, frm);
               act_q.push_back(frm);
            end
         join
         repeat (div_v) @(negedge clk);
         bus_read(uart_pkg::UART_TX_WAIT, rd);
         check("tx wait idle", 32'd0, rd);
      end

      // receive
      bus_write(uart_pkg::UART_RX_EN, 32'd1);
      for (int r = 0; r < RX_FRAMES; r++) begin
         div_v = 4 + int'($urandom % 13);
         b     = 8'($urandom);
         bus_write(uart_pkg::UART_DIV, 32'(div_v));
         @(negedge clk);
         check("rts before frame", 32'd1, 32'(rts));
         send_frame(b, div_v);
         do bus_read(uart_pkg::UART_RX_VALID, rd); while (rd[0] !== 1'b1);
         check("rts during hold", 32'd0, 32'(rts));
         bus_read(uart_pkg::UART_DATA, rd);
         check("rx data", 32'(b), rd);
         bus_read(uart_pkg::UART_RX_VALID, rd);
         check("rx valid cleared", 32'd0, rd);
         check("rts after read", 32'd1, 32'(rts));
      end

      // flow control
      cts = 1'b0;
      repeat (`UART_SYNC_STAGES + 1) @(negedge clk);
      bus_read(uart_pkg::UART_TX_WAIT, rd);
      check("cts low tx wait", 32'd1, rd);
      cts = 1'b1;
      repeat (`UART_SYNC_STAGES) @(negedge clk);
      bus_read(uart_pkg::UART_TX_WAIT, rd);
      check("cts high tx wait", 32'd0, rd);

      // soft reset with a byte left unread
      bus_write(uart_pkg::UART_DIV, 32'd9);
      bus_write(uart_pkg::UART_RX_EN, 32'd1);
      send_frame(8'($urandom), 9);
      do bus_read(uart_pkg::UART_RX_VALID, rd); while (rd[0] !== 1'b1);
      bus_write(uart_pkg::UART_SOFT_RST, 32'd1);
      bus_read(uart_pkg::UART_DIV, rd);
      check("soft reset divider", 32'(`UART_DIV_RESET), rd);
      check("soft reset rts", 32'd0, 32'(rts));
      bus_read(uart_pkg::UART_RX_VALID, rd);
      check("soft reset rx valid", 32'd0, rd);

      repeat (4) @(negedge clk);
      if (act_q.size() == 0 && frames_checked == TX_FRAMES) begin
         $display("Everything OK");
         $finish;
      end else begin
         $display("only %0d of %0d tx frames were compared", frames_checked, TX_FRAMES);
         $display("Something failed");
         $fatal(1, "missing frames");
      end
   end

endmodule

//--- verification/uart_core_sva.sv
`timescale 1ns/1ps

module uart_core_sva (
   input logic clk,
   input logic rst_int,
   input logic valid,
   input logic ready,
   input logic txd,
   input logic rts
);

   // one ready pulse per access
   assert property (@(posedge clk) disable iff (rst_int) ready |=> !ready)
      else $error("ready high for two cycles");

   assert property (@(posedge clk) disable iff (rst_int) ready |-> $past(valid))
      else $error("ready without a preceding valid");

   // serial line idles high while the core is held in reset
   assert property (@(posedge clk) rst_int |-> txd)
      else $error("txd low during reset");

   assert property (@(posedge clk) rst_int |-> !rts)
      else $error("rts high during reset");

endmodule

bind uart_core uart_core_sva i_uart_core_sva (
   .clk     (clk),
   .rst_int (rst_int),
   .valid   (valid),
   .ready   (ready),
   .txd     (txd),
   .rts     (rts)
);

//--- hw/uart_core.sv
`timescale 1ns/1ps

module uart_core (
   input  logic        clk,
   input  logic        rst_int,
   input  logic        valid,
   input  logic        write,
   input  logic [2:0]  address,
   input  logic [31:0] wdata,
   output logic        ready,
   output logic [31:0] rdata,
   output logic        txd,
   output logic        rts,
   input  logic        rxd,
   input  logic        cts
);

   uart_pkg::uart_reg_addr_t reg_addr;
   logic                     soft_rst;
   logic                     uart_rst;

   uart_ctrl_if i_ctrl ();

   assign reg_addr = uart_pkg::uart_reg_addr_t'(address);

   // serial engines and config registers also clear on soft reset
   assign uart_rst = rst_int | soft_rst;

   uart_regs i_uart_regs (
      .clk      (clk),
      .rst_int  (rst_int),
      .uart_rst (uart_rst),
      .valid    (valid),
      .write    (write),
      .address  (reg_addr),
      .wdata    (wdata),
      .ready    (ready),
      .rdata    (rdata),
      .cts      (cts),
      .soft_rst (soft_rst),
      .ctrl     (i_ctrl.regs)
   );

   uart_tx i_uart_tx (
      .clk  (clk),
      .rst  (uart_rst),
      .txd  (txd),
      .ctrl (i_ctrl.tx)
   );

   uart_rx i_uart_rx (
      .clk  (clk),
      .rst  (uart_rst),
      .rxd  (rxd),
      .rts  (rts),
      .ctrl (i_ctrl.rx)
   );

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx (
   input  logic    clk,
   input  logic    rst,
   input  logic    rxd,
   output logic    rts,
   uart_ctrl_if.rx ctrl
);

   localparam int IDX_W = $clog2(`UART_DATA_W);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_HALF,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t                    state;
   logic [`UART_SYNC_STAGES-1:0] rxd_sync;
   logic                         rxd_s;
   logic                         rxd_prev;
   logic                         start;
   uart_pkg::uart_div_t          div_cnt;
   logic [IDX_W-1:0]             bit_idx;
   uart_pkg::uart_byte_t         shift;
   logic                         half_done;
   logic                         bit_done;
   logic                         sample;
   logic                         store;
   logic                         rts_req;

   //////////////////////////////////////////////////////////////////////
   // line synchronizer and start detection
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rxd_sync <= '1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_sync <= {rxd_sync[`UART_SYNC_STAGES-2:0], rxd};
         rxd_prev <= rxd_s;
      end
   end

   assign rxd_s = rxd_sync[`UART_SYNC_STAGES-1];
   assign start = (state == RX_IDLE) && rxd_prev && !rxd_s;

   //////////////////////////////////////////////////////////////////////
   // bit timing FSM
   //////////////////////////////////////////////////////////////////////

   // half period compare, one extra bit for the doubled count
   assign half_done = {div_cnt, 1'b0} >= {1'b0, ctrl.div};
   assign bit_done  = div_cnt >= ctrl.div;
   assign sample    = (state == RX_DATA) && bit_done;
   assign store     = (state == RX_STOP) && bit_done;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= RX_IDLE;
         div_cnt <= '0;
         bit_idx <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               div_cnt <= uart_pkg::uart_div_t'(1);
               if (start) begin
                  state <= RX_HALF;
               end
            end
            RX_HALF: begin
               if (half_done) begin
                  state   <= RX_DATA;
                  div_cnt <= uart_pkg::uart_div_t'(1);
                  bit_idx <= '0;
               end
            end
            RX_DATA: begin
               if (bit_done) begin
                  div_cnt <= uart_pkg::uart_div_t'(1);
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == IDX_W'(`UART_DATA_W - 1)) begin
                     state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               if (bit_done) begin
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge clk) begin
      if (sample) begin
         shift <= {rxd_s, shift[`UART_DATA_W-1:1]};
      end
      if (store) begin
         ctrl.rx_byte <= shift;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // status and flow control
   //////////////////////////////////////////////////////////////////////

   // a new byte wins over a read in the same cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl.rx_valid <= 1'b0;
         rts_req       <= 1'b1;
      end else begin
         if (store) begin
            ctrl.rx_valid <= 1'b1;
         end else if (ctrl.rx_read) begin
            ctrl.rx_valid <= 1'b0;
         end
         if (start) begin
            rts_req <= 1'b0;
         end else if (ctrl.rx_read) begin
            rts_req <= 1'b1;
         end
      end
   end

   assign rts = ctrl.rx_en & rts_req;

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx (
   input  logic    clk,
   input  logic    rst,
   output logic    txd,
   uart_ctrl_if.tx ctrl
);

   // start bit, data bits and one stop bit
   localparam int FRAME_W = `UART_DATA_W + 2;

   logic [FRAME_W-1:0]  frame;
   logic [3:0]          bit_cnt;
   uart_pkg::uart_div_t div_cnt;
   logic                bit_end;

   assign bit_end = (bit_cnt != 4'd0) && (div_cnt == ctrl.div);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         frame   <= '1;
         bit_cnt <= 4'd0;
         div_cnt <= '0;
      end else if (ctrl.tx_load) begin
         // a load during a frame starts over
         frame   <= {1'b1, ctrl.tx_byte, 1'b0};
         bit_cnt <= 4'(FRAME_W);
         div_cnt <= uart_pkg::uart_div_t'(1);
      end else if (bit_end) begin
         frame   <= {1'b1, frame[FRAME_W-1:1]};
         bit_cnt <= bit_cnt - 4'd1;
         // counter parks at zero after the stop bit
         if (bit_cnt == 4'd1) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= uart_pkg::uart_div_t'(1);
         end
      end else if (bit_cnt != 4'd0) begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign ctrl.tx_busy = (bit_cnt != 4'd0);
   assign txd          = frame[0];

endmodule

//--- hw/uart_regs.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_regs (
   input  logic                     clk,
   input  logic                     rst_int,
   input  logic                     uart_rst,
   input  logic                     valid,
   input  logic                     write,
   input  uart_pkg::uart_reg_addr_t address,
   input  logic [31:0]              wdata,
   output logic                     ready,
   output logic [31:0]              rdata,
   input  logic                     cts,
   output logic                     soft_rst,
   uart_ctrl_if.regs                ctrl
);

   logic                         accept;
   logic                         wr_div;
   logic                         wr_rx_en;
   logic                         wr_soft_rst;
   logic [`UART_SYNC_STAGES-1:0] cts_sync;
   logic                         tx_wait;
   logic [31:0]                  rd_mux;

   //////////////////////////////////////////////////////////////////////
   // bus acceptance
   //////////////////////////////////////////////////////////////////////

   // one access per valid, ready follows one cycle later
   assign accept = valid & ~ready;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready <= 1'b0;
      end else begin
         ready <= accept;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // write decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      ctrl.tx_load = 1'b0;
      ctrl.rx_read = 1'b0;
      wr_div       = 1'b0;
      wr_rx_en     = 1'b0;
      wr_soft_rst  = 1'b0;
      if (accept) begin
         case (address)
            uart_pkg::UART_DIV:      wr_div = write;
            uart_pkg::UART_DATA: begin
               ctrl.tx_load = write;
               ctrl.rx_read = ~write;
            end
            uart_pkg::UART_SOFT_RST: wr_soft_rst = write;
            uart_pkg::UART_RX_EN:    wr_rx_en = write;
            default: ;
         endcase
      end
   end

   assign ctrl.tx_byte = wdata[`UART_DATA_W-1:0];

   // divider and receive enable return to defaults on soft reset too
   always_ff @(posedge clk or posedge uart_rst) begin
      if (uart_rst) begin
         ctrl.div   <= uart_pkg::uart_div_t'(`UART_DIV_RESET);
         ctrl.rx_en <= 1'b0;
      end else begin
         if (wr_div) begin
            ctrl.div <= wdata[`UART_DIV_W-1:0];
         end
         if (wr_rx_en) begin
            ctrl.rx_en <= wdata[0];
         end
      end
   end

   // single cycle pulse
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_rst <= 1'b0;
      end else begin
         soft_rst <= wr_soft_rst & wdata[0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // flow control and read mux
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         cts_sync <= '1;
      end else begin
         cts_sync <= {cts_sync[`UART_SYNC_STAGES-2:0], cts};
      end
   end

   // far end not ready counts as busy
   assign tx_wait = ctrl.tx_busy | ~cts_sync[`UART_SYNC_STAGES-1];

   always_comb begin
      rd_mux = '1;
      case (address)
         uart_pkg::UART_DIV:      rd_mux = 32'(ctrl.div);
         uart_pkg::UART_DATA:     rd_mux = 32'(ctrl.rx_byte);
         uart_pkg::UART_TX_WAIT:  rd_mux = {31'd0, tx_wait};
         uart_pkg::UART_RX_VALID: rd_mux = {31'd0, ctrl.rx_valid};
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (accept && !write) begin
         rdata <= rd_mux;
      end
   end

endmodule

//--- hw/uart_ctrl_if.sv
`timescale 1ns/1ps

interface uart_ctrl_if;

   // bit period shared by both engines
   uart_pkg::uart_div_t  div;

   // transmit side
   logic                 tx_load;
   uart_pkg::uart_byte_t tx_byte;
   logic                 tx_busy;

   // receive side
   logic                 rx_read;
   logic                 rx_en;
   uart_pkg::uart_byte_t rx_byte;
   logic                 rx_valid;

   modport regs (
      output div, tx_load, tx_byte, rx_read, rx_en,
      input  tx_busy, rx_byte, rx_valid
   );

   modport tx (
      input  div, tx_load, tx_byte,
      output tx_busy
   );

   modport rx (
      input  div, rx_read, rx_en,
      output rx_byte, rx_valid
   );

endinterface

//--- hw/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

   //////////////////////////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////////////////////////

   // addresses 6 and 7 are unmapped and read as all ones
   typedef enum logic [2:0] {
      UART_DIV       = 3'd0,
      UART_DATA      = 3'd1,
      UART_SOFT_RST  = 3'd2,
      UART_RX_EN     = 3'd3,
      UART_TX_WAIT   = 3'd4,
      UART_RX_VALID  = 3'd5
   } uart_reg_addr_t;

   //////////////////////////////////////////////////////////////////////
   // payload types
   //////////////////////////////////////////////////////////////////////

   // one serial character
   typedef logic [`UART_DATA_W-1:0] uart_byte_t;

   // clock cycles per serial bit
   typedef logic [`UART_DIV_W-1:0] uart_div_t;

endpackage

//--- hw/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// width of one serial byte
`define UART_DATA_W 8

// divider register and bit timing counters
`define UART_DIV_W 16

// clock cycles per bit after any reset
`define UART_DIV_RESET 1

// flops in the cts and rxd synchronizers, at least 2
`define UART_SYNC_STAGES 2

`endif
